//--- Bender.yml
package:
  name: cdc_fifo_bank

sources:
  - cdc_gray_pkg.sv
  - cdc_bank_pkg.sv
  - cdc_push_flag_mgr.sv
  - cdc_pop_flag_mgr.sv
  - cdc_fifo_lane.sv
  - cdc_lane_dispatch.sv
  - cdc_lane_drain.sv
  - cdc_fifo_bank.sv
  - target: test
    files:
      - tb_cdc_fifo_bank.sv

//--- cdc_bank_pkg.sv
// Lane bank helpers
package cdc_bank_pkg;

  // Upper bound on the request vector seen by the arbiter
  localparam int MaxLanes = 32;

  // Lane index width, never below one bit
  function automatic int lane_idx_width(input int num_lanes);
    return (num_lanes > 1) ? $clog2(num_lanes) : 1;
  endfunction

  // First requesting index after last, wrapping at num_lanes
  // Returns last when nothing requests
  function automatic int rr_next(input logic [MaxLanes-1:0] req, input int last,
                                 input int num_lanes);
    int idx;
    int pick;
    logic found;
    pick = last;
    found = 1'b0;
    for (int k = 1; k <= MaxLanes; k++) begin
      if (k <= num_lanes) begin
        idx = last + k;
        if (idx >= num_lanes) begin
          idx = idx - num_lanes;
        end
        if (!found && req[idx]) begin
          pick = idx;
          found = 1'b1;
        end
      end
    end
    return pick;
  endfunction

endpackage

//--- cdc_fifo_bank.sv
// Multi-lane CDC FIFO bank
module cdc_fifo_bank
  import cdc_gray_pkg::*;
  import cdc_bank_pkg::*;
#(
  parameter int NumLanes = 4,
  parameter int Depth = 4,
  parameter int DataWidth = 16,
  localparam int CountWidth = count_width(Depth),
  localparam int LaneIdxWidth = lane_idx_width(NumLanes)
) (
  input  logic                                push_clk,
  input  logic                                pop_clk,
  input  logic                                rst_n,
  input  logic                                push_valid,
  input  logic [LaneIdxWidth-1:0]             push_lane,
  input  logic [DataWidth-1:0]                push_data,
  input  logic                                pop_en,
  output logic [NumLanes-1:0]                 lane_full,
  output logic [NumLanes-1:0][CountWidth-1:0] lane_slots,
  output logic                                pop_valid,
  output logic [LaneIdxWidth-1:0]             pop_lane,
  output logic [DataWidth-1:0]                pop_data
);

  logic [NumLanes-1:0]                lane_push_beat;
  logic [NumLanes-1:0]                lane_pop_beat;
  logic [NumLanes-1:0]                lane_empty;
  logic [NumLanes-1:0][DataWidth-1:0] lane_rd_data;

  cdc_lane_dispatch #(
    .NumLanes(NumLanes)
  ) u_dispatch (
    .push_clk      (push_clk),
    .rst_n         (rst_n),
    .push_valid    (push_valid),
    .push_lane     (push_lane),
    .lane_full_in  (lane_full),
    .lane_push_beat(lane_push_beat)
  );

  for (genvar i = 0; i < NumLanes; i++) begin : g_lane
    cdc_fifo_lane #(
      .Depth    (Depth),
      .DataWidth(DataWidth)
    ) u_lane (
      .push_clk (push_clk),
      .pop_clk  (pop_clk),
      .rst_n    (rst_n),
      .push_beat(lane_push_beat[i]),
      .push_data(push_data),
      .pop_beat (lane_pop_beat[i]),
      .full     (lane_full[i]),
      .slots    (lane_slots[i]),
      .empty    (lane_empty[i]),
      .rd_data  (lane_rd_data[i])
    );
  end

  cdc_lane_drain #(
    .NumLanes (NumLanes),
    .DataWidth(DataWidth)
  ) u_drain (
    .pop_clk      (pop_clk),
    .rst_n        (rst_n),
    .pop_en       (pop_en),
    .lane_empty   (lane_empty),
    .lane_rd_data (lane_rd_data),
    .lane_pop_beat(lane_pop_beat),
    .pop_valid    (pop_valid),
    .pop_lane     (pop_lane),
    .pop_data     (pop_data)
  );

endmodule

//--- cdc_fifo_lane.sv
// Dual clock FIFO lane
module cdc_fifo_lane
  import cdc_gray_pkg::*;
#(
  parameter int Depth = 4,
  parameter int DataWidth = 16,
  localparam int CountWidth = count_width(Depth),
  localparam int AddrWidth = $clog2(Depth)
) (
  input  logic                  push_clk,
  input  logic                  pop_clk,
  input  logic                  rst_n,
  input  logic                  push_beat,
  input  logic [DataWidth-1:0]  push_data,
  input  logic                  pop_beat,
  output logic                  full,
  output logic [CountWidth-1:0] slots,
  output logic                  empty,
  output logic [DataWidth-1:0]  rd_data
);

  logic [DataWidth-1:0]  mem [Depth];
  logic [AddrWidth-1:0]  wr_addr;
  logic [AddrWidth-1:0]  rd_addr;
  logic [CountWidth-1:0] push_count_gray;
  logic [CountWidth-1:0] pop_count_gray;
  logic [CountWidth-1:0] push_gray_meta;
  logic [CountWidth-1:0] push_gray_sync;
  logic [CountWidth-1:0] pop_gray_meta;
  logic [CountWidth-1:0] pop_gray_sync;

  // Write pointer tracks the push count modulo Depth
  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      wr_addr <= '0;
    end else if (push_beat) begin
      if (wr_addr == AddrWidth'(Depth - 1)) begin
        wr_addr <= '0;
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  always_ff @(posedge push_clk) begin
    if (push_beat) begin
      mem[wr_addr] <= push_data;
    end
  end

  assign rd_data = mem[rd_addr];

  // Push count into the pop domain
  always_ff @(posedge pop_clk) begin
    if (!rst_n) begin
      push_gray_meta <= '0;
      push_gray_sync <= '0;
    end else begin
      push_gray_meta <= push_count_gray;
      push_gray_sync <= push_gray_meta;
    end
  end

  // Pop count into the push domain
  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      pop_gray_meta <= '0;
      pop_gray_sync <= '0;
    end else begin
      pop_gray_meta <= pop_count_gray;
      pop_gray_sync <= pop_gray_meta;
    end
  end

  cdc_push_flag_mgr #(
    .Depth(Depth)
  ) u_push_flags (
    .push_clk       (push_clk),
    .rst_n          (rst_n),
    .push_beat      (push_beat),
    .pop_count_gray (pop_gray_sync),
    .push_count_gray(push_count_gray),
    .slots          (slots),
    .full           (full)
  );

  cdc_pop_flag_mgr #(
    .Depth(Depth)
  ) u_pop_flags (
    .pop_clk        (pop_clk),
    .rst_n          (rst_n),
    .pop_beat       (pop_beat),
    .push_count_gray(push_gray_sync),
    .pop_count_gray (pop_count_gray),
    .rd_addr        (rd_addr),
    .empty          (empty)
  );

endmodule

//--- cdc_gray_pkg.sv
// Gray code helpers
package cdc_gray_pkg;

  // Widest count the conversion functions handle
  localparam int MaxGrayWidth = 16;

  // Bits needed to hold 0 to depth inclusive
  function automatic int count_width(input int depth);
    return $clog2(depth + 1);
  endfunction

  function automatic logic [MaxGrayWidth-1:0] bin2gray(input logic [MaxGrayWidth-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  // Each binary bit is the XOR of all Gray bits at or above it
  function automatic logic [MaxGrayWidth-1:0] gray2bin(input logic [MaxGrayWidth-1:0] gray);
    logic [MaxGrayWidth-1:0] bin;
    bin[MaxGrayWidth-1] = gray[MaxGrayWidth-1];
    for (int i = MaxGrayWidth - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

//--- cdc_lane_dispatch.sv
// Push lane decoder
module cdc_lane_dispatch
  import cdc_bank_pkg::*;
#(
  parameter int NumLanes = 4,
  localparam int LaneIdxWidth = lane_idx_width(NumLanes)
) (
  input  logic                    push_clk,
  input  logic                    rst_n,
  input  logic                    push_valid,
  input  logic [LaneIdxWidth-1:0] push_lane,
  input  logic [NumLanes-1:0]     lane_full_in,
  output logic [NumLanes-1:0]     lane_push_beat
);

  // One-hot strobe, an out of range index selects nothing
  always_comb begin
    lane_push_beat = '0;
    for (int i = 0; i < NumLanes; i++) begin
      lane_push_beat[i] = push_valid && (push_lane == LaneIdxWidth'(i));
    end
  end

  // Clock and reset exist only for these checks

  lane_in_range_a: assert property (
    @(posedge push_clk) disable iff (!rst_n)
    push_valid |-> (push_lane < NumLanes)
  ) else $error("push lane %0d out of range", push_lane);

  // Full comes back from the lanes, so this ties producer to lane state
  no_push_to_full_lane_a: assert property (
    @(posedge push_clk) disable iff (!rst_n)
    (lane_push_beat & lane_full_in) == '0
  ) else $error("push to full lane %0d", push_lane);

endmodule

//--- cdc_lane_drain.sv
// Round-robin lane drain
module cdc_lane_drain
  import cdc_bank_pkg::*;
#(
  parameter int NumLanes = 4,
  parameter int DataWidth = 16,
  localparam int LaneIdxWidth = lane_idx_width(NumLanes)
) (
  input  logic                                pop_clk,
  input  logic                                rst_n,
  input  logic                                pop_en,
  input  logic [NumLanes-1:0]                 lane_empty,
  input  logic [NumLanes-1:0][DataWidth-1:0]  lane_rd_data,
  output logic [NumLanes-1:0]                 lane_pop_beat,
  output logic                                pop_valid,
  output logic [LaneIdxWidth-1:0]             pop_lane,
  output logic [DataWidth-1:0]                pop_data
);

  logic [NumLanes-1:0]     lane_req;
  logic [LaneIdxWidth-1:0] last_lane;
  logic [LaneIdxWidth-1:0] sel_lane;
  logic                    pop_any;
  int                      next_lane;

  assign lane_req = ~lane_empty;
  assign pop_any  = pop_en && (|lane_req);

  assign next_lane = rr_next(MaxLanes'(lane_req), int'(last_lane), NumLanes);
  assign sel_lane  = LaneIdxWidth'(next_lane);

  always_comb begin
    lane_pop_beat = '0;
    if (pop_any) begin
      lane_pop_beat[sel_lane] = 1'b1;
    end
  end

  // Start pointing at the last lane so lane 0 is served first
  always_ff @(posedge pop_clk) begin
    if (!rst_n) begin
      last_lane <= LaneIdxWidth'(NumLanes - 1);
      pop_valid <= 1'b0;
    end else begin
      pop_valid <= pop_any;
      if (pop_any) begin
        last_lane <= sel_lane;
      end
    end
  end

  always_ff @(posedge pop_clk) begin
    if (pop_any) begin
      pop_lane <= sel_lane;
      pop_data <= lane_rd_data[sel_lane];
    end
  end

  // Arbiter grant must land on a lane that holds data
  grant_has_data_a: assert property (
    @(posedge pop_clk) disable iff (!rst_n)
    (lane_pop_beat & lane_empty) == '0
  ) else $error("pop granted to empty lane %0d", sel_lane);

endmodule

//--- cdc_pop_flag_mgr.sv
// Pop side flag manager
module cdc_pop_flag_mgr
  import cdc_gray_pkg::*;
#(
  parameter int Depth = 4,
  localparam int CountWidth = count_width(Depth),
  localparam int AddrWidth = $clog2(Depth)
) (
  input  logic                  pop_clk,
  input  logic                  rst_n,
  input  logic                  pop_beat,
  input  logic [CountWidth-1:0] push_count_gray,
  output logic [CountWidth-1:0] pop_count_gray,
  output logic [AddrWidth-1:0]  rd_addr,
  output logic                  empty
);

  localparam logic [CountWidth:0] WrapOffset = {1'b1, {CountWidth{1'b0}}};

  logic [CountWidth-1:0] pop_count;
  logic [CountWidth-1:0] push_count;
  logic [CountWidth:0]   push_count_ext;
  logic [CountWidth:0]   pop_count_ext;
  logic [CountWidth:0]   items_ext;

  // Binary count wraps at 2**CountWidth, read address wraps at Depth
  always_ff @(posedge pop_clk) begin
    if (!rst_n) begin
      pop_count <= '0;
      rd_addr   <= '0;
    end else if (pop_beat) begin
      pop_count <= pop_count + 1'b1;
      if (rd_addr == AddrWidth'(Depth - 1)) begin
        rd_addr <= '0;
      end else begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  always_ff @(posedge pop_clk) begin
    if (!rst_n) begin
      pop_count_gray <= '0;
    end else begin
      pop_count_gray <= CountWidth'(bin2gray(MaxGrayWidth'(pop_count)));
    end
  end

  assign push_count = CountWidth'(gray2bin(MaxGrayWidth'(push_count_gray)));

  assign push_count_ext = {1'b0, push_count};
  assign pop_count_ext  = {1'b0, pop_count};

  assign items_ext = (push_count_ext >= pop_count_ext) ?
      (push_count_ext - pop_count_ext) :
      (push_count_ext + WrapOffset - pop_count_ext);

  // Lagging push count can only hide items, never invent them
  assign empty = (items_ext == '0);

  no_pop_when_empty_a: assert property (
    @(posedge pop_clk) disable iff (!rst_n)
    pop_beat |-> !empty
  ) else $error("pop beat while lane empty");

endmodule

//--- cdc_push_flag_mgr.sv
// Push side flag manager
module cdc_push_flag_mgr
  import cdc_gray_pkg::*;
#(
  parameter int Depth = 4,
  localparam int CountWidth = count_width(Depth)
) (
  input  logic                  push_clk,
  input  logic                  rst_n,
  input  logic                  push_beat,
  input  logic [CountWidth-1:0] pop_count_gray,
  output logic [CountWidth-1:0] push_count_gray,
  output logic [CountWidth-1:0] slots,
  output logic                  full
);

  // Counts wrap at 2**CountWidth, so add this back when pop is ahead
  localparam logic [CountWidth:0] WrapOffset = {1'b1, {CountWidth{1'b0}}};

  logic [CountWidth-1:0] push_count;
  logic [CountWidth-1:0] pop_count;
  logic [CountWidth:0]   push_count_ext;
  logic [CountWidth:0]   pop_count_ext;
  logic [CountWidth:0]   items_ext;

  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      push_count <= '0;
    end else if (push_beat) begin
      push_count <= push_count + 1'b1;
    end
  end

  // Published one cycle after the count, so the data write has landed
  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      push_count_gray <= '0;
    end else begin
      push_count_gray <= CountWidth'(bin2gray(MaxGrayWidth'(push_count)));
    end
  end

  // Pop count arrives already synchronized, decode only
  assign pop_count = CountWidth'(gray2bin(MaxGrayWidth'(pop_count_gray)));

  assign push_count_ext = {1'b0, push_count};
  assign pop_count_ext  = {1'b0, pop_count};

  assign items_ext = (push_count_ext >= pop_count_ext) ?
      (push_count_ext - pop_count_ext) :
      (push_count_ext + WrapOffset - pop_count_ext);

  // Stale pop count only ever overstates occupancy
  assign slots = CountWidth'(Depth) - items_ext[CountWidth-1:0];
  assign full  = (slots == '0);

  // Lagging pop count must never make the lane look overfilled
  no_overflow_a: assert property (
    @(posedge push_clk) disable iff (!rst_n)
    items_ext <= Depth
  ) else $error("push side occupancy %0d exceeds depth %0d", items_ext, Depth);

  // Producer contract, checked where the count would break
  no_push_when_full_a: assert property (
    @(posedge push_clk) disable iff (!rst_n)
    push_beat |-> !full
  ) else $error("push beat while lane full");

endmodule

//--- filelist.f
cdc_gray_pkg.sv
cdc_bank_pkg.sv
cdc_push_flag_mgr.sv
cdc_pop_flag_mgr.sv
cdc_fifo_lane.sv
cdc_lane_dispatch.sv
cdc_lane_drain.sv
cdc_fifo_bank.sv
tb_cdc_fifo_bank.sv

//--- tb_cdc_fifo_bank.sv
// CDC FIFO bank testbench
module tb_cdc_fifo_bank
  import cdc_gray_pkg::*;
  import cdc_bank_pkg::*;
();

  localparam int NumLanes = 4;
  localparam int Depth = 4;
  localparam int DataWidth = 16;
  localparam int CountWidth = count_width(Depth);
  localparam int LaneIdxWidth = lane_idx_width(NumLanes);
  localparam int RandomAttempts = 600;
  // Two push cycles per attempt at most, plus fill, round-robin and drain phases
  localparam int MaxCycles = 4000;

  logic                                push_clk = 1'b0;
  logic                                pop_clk = 1'b0;
  logic                                rst_n;
  logic                                push_valid;
  logic [LaneIdxWidth-1:0]             push_lane;
  logic [DataWidth-1:0]                push_data;
  logic                                pop_en;
  logic [NumLanes-1:0]                 lane_full;
  logic [NumLanes-1:0][CountWidth-1:0] lane_slots;
  logic                                pop_valid;
  logic [LaneIdxWidth-1:0]             pop_lane;
  logic [DataWidth-1:0]                pop_data;

  // Scoreboard, one queue of pushed beats per lane
  logic [DataWidth-1:0] exp_q [NumLanes][$];
  int seed = 32'h492e;
  int cycle_count = 0;
  bit rr_active = 1'b0;
  int rr_count = 0;
  int rr_first = 0;

  always #5 push_clk = ~push_clk;
  // Unrelated period keeps the domains asynchronous
  always #7 pop_clk = ~pop_clk;

  cdc_fifo_bank #(
    .NumLanes (NumLanes),
    .Depth    (Depth),
    .DataWidth(DataWidth)
  ) i_dut (
    .push_clk  (push_clk),
    .pop_clk   (pop_clk),
    .rst_n     (rst_n),
    .push_valid(push_valid),
    .push_lane (push_lane),
    .push_data (push_data),
    .pop_en    (pop_en),
    .lane_full (lane_full),
    .lane_slots(lane_slots),
    .pop_valid (pop_valid),
    .pop_lane  (pop_lane),
    .pop_data  (pop_data)
  );

  task automatic value_error(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    $display("ERROR at %0t: %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
    $display("TB FAILED");
    $fatal(1, "mismatch on %s", name);
  endtask

  task automatic abort_run(input string what);
    $display("Run stopped at %0t: %s", $time, what);
    $display("TB FAILED");
    $fatal(1, "%s", what);
  endtask

  // Entered and left at a falling push_clk edge, where the flags are settled
  task automatic push_one(input int lane, input logic [DataWidth-1:0] data, output bit done);
    done = 1'b0;
    if (!lane_full[lane]) begin
      @(posedge push_clk);
      push_valid <= 1'b1;
      push_lane  <= LaneIdxWidth'(lane);
      push_data  <= data;
      @(posedge push_clk);
      push_valid <= 1'b0;
      exp_q[lane].push_back(data);
      done = 1'b1;
    end
    @(negedge push_clk);
  endtask

  task automatic set_pop_en(input logic value);
    @(posedge pop_clk);
    pop_en <= value;
    @(negedge push_clk);
  endtask

  task automatic check_slots(input int lane, input int expected);
    assert (lane_slots[lane] == CountWidth'(expected))
      else value_error($sformatf("lane_slots[%0d]", lane), expected, lane_slots[lane]);
    assert (lane_full[lane] == (expected == 0))
      else value_error($sformatf("lane_full[%0d]", lane), expected == 0, lane_full[lane]);
  endtask

  function automatic bit all_drained();
    bit drained;
    drained = 1'b1;
    for (int i = 0; i < NumLanes; i++) begin
      if (exp_q[i].size() != 0 || lane_slots[i] != CountWidth'(Depth)) begin
        drained = 1'b0;
      end
    end
    return drained;
  endfunction

  always @(posedge push_clk) begin
    cycle_count++;
    assert (cycle_count <= MaxCycles)
      else abort_run($sformatf("timeout after %0d push_clk cycles", MaxCycles));
  end

  // Output order, integrity and round-robin rotation
  always @(negedge pop_clk) begin
    int lane;
    if (rst_n && pop_valid) begin
      lane = int'(pop_lane);
      assert (exp_q[lane].size() != 0)
        else abort_run($sformatf("pop from lane %0d with nothing pushed", lane));
      assert (pop_data == exp_q[lane][0])
        else value_error($sformatf("pop_data lane %0d", lane), exp_q[lane][0], pop_data);
      void'(exp_q[lane].pop_front());
      if (rr_active && rr_count < NumLanes * Depth) begin
        if (rr_count == 0) begin
          rr_first = lane;
        end else begin
          assert (lane == (rr_first + rr_count) % NumLanes)
            else value_error("pop_lane", (rr_first + rr_count) % NumLanes, lane);
        end
        rr_count++;
      end
    end
  end

  // Not full must mean fewer than Depth beats outstanding
  always @(negedge push_clk) begin
    if (rst_n) begin
      for (int i = 0; i < NumLanes; i++) begin
        assert (lane_full[i] || exp_q[i].size() < Depth)
          else abort_run($sformatf("lane %0d not full with %0d beats outstanding",
                                   i, exp_q[i].size()));
      end
    end
  end

  initial begin
    bit          done;
    logic [31:0] rnd;
    int          lane;
    int          pushed;
    rst_n      = 1'b0;
    push_valid = 1'b0;
    push_lane  = '0;
    push_data  = '0;
    pop_en     = 1'b0;
    pushed     = 0;
    repeat (5) @(posedge pop_clk);
    rst_n <= 1'b1;
    @(negedge push_clk);

    assert (pop_valid == 1'b0) else value_error("pop_valid", 0, pop_valid);
    for (int i = 0; i < NumLanes; i++) begin
      check_slots(i, Depth);
    end

    // Lane 0 counts down with the drain stopped
    for (int k = 0; k < Depth; k++) begin
      check_slots(0, Depth - k);
      rnd = $random(seed);
      push_one(0, rnd[DataWidth-1:0], done);
      assert (done) else abort_run("lane 0 refused a push while filling");
    end
    for (int i = 0; i < NumLanes; i++) begin
      check_slots(i, (i == 0) ? 0 : Depth);
    end

    for (int i = 1; i < NumLanes; i++) begin
      for (int k = 0; k < Depth; k++) begin
        rnd = $random(seed);
        push_one(i, rnd[DataWidth-1:0], done);
        assert (done) else abort_run($sformatf("lane %0d refused a push while filling", i));
      end
    end

    // Let the push counts cross before draining
    repeat (8) @(posedge pop_clk);
    rr_active = 1'b1;
    set_pop_en(1'b1);
    while (rr_count < NumLanes * Depth) @(negedge push_clk);
    rr_active = 1'b0;
    while (!all_drained()) @(negedge push_clk);

    // Mixed traffic, drain stopped in every third block of 40 attempts
    for (int n = 0; n < RandomAttempts; n++) begin
      if (n % 40 == 0) begin
        set_pop_en((n / 40) % 3 != 1);
      end
      lane = int'($unsigned($random(seed)) % NumLanes);
      rnd = $random(seed);
      push_one(lane, rnd[DataWidth-1:0], done);
      if (done) begin
        pushed++;
      end
    end
    set_pop_en(1'b1);
    while (!all_drained()) @(negedge push_clk);
    for (int i = 0; i < NumLanes; i++) begin
      check_slots(i, Depth);
    end
    repeat (3) @(negedge pop_clk);
    assert (pop_valid == 1'b0) else value_error("pop_valid", 0, pop_valid);
    $display("%0d beats pushed in the mixed phase", pushed);
    $display("TB PASSED");
    $finish;
  end

endmodule
